// ==== logic/bypass_pkg.sv ====
/*
 * Shared definitions for the three-stage integer pipeline.
 * Data and register address widths, opcodes and forwarding select encodings.
 */
package bypass_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Data path width
  localparam int XLEN      = 32;
  // Register file address width and depth
  localparam int RF_ADDR_W = 5;
  localparam int RF_NUM    = 2 ** RF_ADDR_W;

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////

  // Decoded operations as they arrive at the top level
  typedef enum logic [2:0] {
    OP_NOP  = 3'd0,
    OP_ADD  = 3'd1,
    OP_SUB  = 3'd2,
    OP_XOR  = 3'd3,
    OP_ADDI = 3'd4,
    OP_LOAD = 3'd5,
    OP_JALR = 3'd6
  } op_e;

  // Operand forwarding select
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fw_sel_e;

  // Jump register forwarding select, WB only
  typedef enum logic [0:0] {
    SELJ_REGFILE = 1'b0,
    SELJ_FW_WB   = 1'b1
  } jfw_sel_e;

endpackage

// ==== logic/ex_stage.sv ====
`timescale 1ns/1ps
/*
 * Execute stage.
 * ALU, one load request per load and the EX/WB register.
 */
module ex_stage (
  input  logic                             clk,
  input  logic                             reset_i,
  input  logic                             id_ex_valid_i,
  input  bypass_pkg::op_e                  id_ex_op_i,
  input  logic [bypass_pkg::RF_ADDR_W-1:0] id_ex_rd_i,
  input  logic [bypass_pkg::XLEN-1:0]      id_ex_opa_i,
  input  logic [bypass_pkg::XLEN-1:0]      id_ex_opb_i,
  input  logic                             wb_ready_i,
  output logic                             ex_valid_o,
  output logic                             ex_we_o,
  output logic                             ex_load_o,
  output logic [bypass_pkg::RF_ADDR_W-1:0] ex_waddr_o,
  output logic [bypass_pkg::XLEN-1:0]      ex_result_o,
  output logic                             mem_req_o,
  output logic [bypass_pkg::XLEN-1:0]      mem_addr_o,
  output logic                             ex_wb_valid_o,
  output logic                             ex_wb_load_o,
  output logic [bypass_pkg::RF_ADDR_W-1:0] ex_wb_rd_o,
  output logic [bypass_pkg::XLEN-1:0]      ex_wb_result_o
);

  // Request for the load in EX already issued
  logic req_sent_q;

  // ALU, loads use the adder for the address
  always_comb begin
    ex_we_o     = 1'b1;
    ex_result_o = id_ex_opa_i + id_ex_opb_i;
    case (id_ex_op_i)
      bypass_pkg::OP_SUB: ex_result_o = id_ex_opa_i - id_ex_opb_i;
      bypass_pkg::OP_XOR: ex_result_o = id_ex_opa_i ^ id_ex_opb_i;
      bypass_pkg::OP_ADD, bypass_pkg::OP_ADDI, bypass_pkg::OP_LOAD: ;
      default: ex_we_o = 1'b0;
    endcase
  end

  assign ex_valid_o = id_ex_valid_i;
  assign ex_load_o  = (id_ex_op_i == bypass_pkg::OP_LOAD);
  assign ex_waddr_o = id_ex_rd_i;

  // Request on the first EX cycle only
  assign mem_req_o  = id_ex_valid_i && ex_load_o && !req_sent_q;
  assign mem_addr_o = ex_result_o;

  always_ff @(posedge clk) begin
    if (reset_i || wb_ready_i) begin
      req_sent_q <= 1'b0;
    end else if (mem_req_o) begin
      req_sent_q <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      ex_wb_valid_o <= 1'b0;
    end else if (wb_ready_i) begin
      ex_wb_valid_o <= id_ex_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (wb_ready_i) begin
      ex_wb_load_o   <= ex_load_o;
      ex_wb_rd_o     <= id_ex_rd_i;
      ex_wb_result_o <= ex_result_o;
    end
  end

  // A load held in EX does not request again
  req_once: assert property (@(posedge clk) disable iff (reset_i)
    (mem_req_o && !wb_ready_i) |=> !mem_req_o);

endmodule

// ==== logic/hazard_bypass_ctrl.sv ====
`timescale 1ns/1ps
/*
 * Hazard and bypass controller.
 * Matches ID source registers against the EX and WB destinations and
 * drives the forwarding selects, the load-use stall and the JALR stall.
 */
module hazard_bypass_ctrl (
  input  logic [1:0]                       rf_re_i,
  input  logic [bypass_pkg::RF_ADDR_W-1:0] rf_raddr_a_i,
  input  logic [bypass_pkg::RF_ADDR_W-1:0] rf_raddr_b_i,
  input  logic                             jalr_id_i,
  input  logic                             ex_valid_i,
  input  logic                             ex_we_i,
  input  logic                             ex_load_i,
  input  logic [bypass_pkg::RF_ADDR_W-1:0] ex_waddr_i,
  input  logic                             wb_valid_i,
  input  logic                             wb_we_i,
  input  logic                             wb_load_i,
  input  logic [bypass_pkg::RF_ADDR_W-1:0] wb_waddr_i,
  input  logic                             wb_ready_i,
  output bypass_pkg::fw_sel_e              operand_a_sel_o,
  output bypass_pkg::fw_sel_e              operand_b_sel_o,
  output bypass_pkg::jfw_sel_e             jalr_sel_o,
  output logic                             load_stall_o,
  output logic                             jr_stall_o
);

  // Qualified write enables
  logic       rf_we_ex;
  logic       rf_we_wb;
  logic       load_ex;
  logic       load_wb;
  // Per read port address matches, r0 excluded
  logic [1:0] ex_match;
  logic [1:0] wb_match;
  // JALR always reads rs1, read enable not needed
  logic       ex_jr_match;
  logic       wb_jr_match;

  assign rf_we_ex = ex_valid_i && ex_we_i;
  assign rf_we_wb = wb_valid_i && wb_we_i;
  assign load_ex  = rf_we_ex && ex_load_i;
  assign load_wb  = rf_we_wb && wb_load_i;

  assign ex_match[0] = rf_re_i[0] && (rf_raddr_a_i == ex_waddr_i) && |rf_raddr_a_i;
  assign ex_match[1] = rf_re_i[1] && (rf_raddr_b_i == ex_waddr_i) && |rf_raddr_b_i;
  assign wb_match[0] = rf_re_i[0] && (rf_raddr_a_i == wb_waddr_i) && |rf_raddr_a_i;
  assign wb_match[1] = rf_re_i[1] && (rf_raddr_b_i == wb_waddr_i) && |rf_raddr_b_i;

  assign ex_jr_match = (rf_raddr_a_i == ex_waddr_i) && |rf_raddr_a_i;
  assign wb_jr_match = (rf_raddr_a_i == wb_waddr_i) && |rf_raddr_a_i;

  //////////////////////////////////////////////////
  // Stalls
  //////////////////////////////////////////////////

  always_comb begin
    load_stall_o = 1'b0;
    jr_stall_o   = 1'b0;
    // Load result not available yet, in EX or still waiting in WB
    if ((load_ex && |ex_match) || (!wb_ready_i && load_wb && |wb_match)) begin
      load_stall_o = 1'b1;
    end
    // Target path only takes an ALU result from WB
    if (jalr_id_i && ((rf_we_ex && ex_jr_match) || (load_wb && wb_jr_match))) begin
      jr_stall_o = 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Forwarding selects
  //////////////////////////////////////////////////

  always_comb begin
    operand_a_sel_o = bypass_pkg::SEL_REGFILE;
    operand_b_sel_o = bypass_pkg::SEL_REGFILE;
    jalr_sel_o      = bypass_pkg::SELJ_REGFILE;

    // WB first, EX overrides below as the younger writer
    if (rf_we_wb) begin
      if (wb_match[0]) begin
        operand_a_sel_o = bypass_pkg::SEL_FW_WB;
      end
      if (wb_match[1]) begin
        operand_b_sel_o = bypass_pkg::SEL_FW_WB;
      end
      if (wb_jr_match && !wb_load_i) begin
        jalr_sel_o = bypass_pkg::SELJ_FW_WB;
      end
    end

    // A load in EX has only an address, the stall covers it
    if (rf_we_ex && !ex_load_i) begin
      if (ex_match[0]) begin
        operand_a_sel_o = bypass_pkg::SEL_FW_EX;
      end
      if (ex_match[1]) begin
        operand_b_sel_o = bypass_pkg::SEL_FW_EX;
      end
    end
  end

endmodule

// ==== logic/id_stage.sv ====
`timescale 1ns/1ps
/*
 * Instruction decode stage.
 * Forwarding muxes, JALR target, stall gating and the ID/EX register.
 */
module id_stage (
  input  logic                             clk,
  input  logic                             reset_i,
  input  logic                             instr_valid_i,
  input  bypass_pkg::op_e                  op_i,
  input  logic [bypass_pkg::RF_ADDR_W-1:0] rd_i,
  input  logic [bypass_pkg::RF_ADDR_W-1:0] rs1_i,
  input  logic [bypass_pkg::RF_ADDR_W-1:0] rs2_i,
  input  logic [bypass_pkg::XLEN-1:0]      imm_i,
  input  logic [bypass_pkg::XLEN-1:0]      rf_rdata_a_i,
  input  logic [bypass_pkg::XLEN-1:0]      rf_rdata_b_i,
  input  logic [bypass_pkg::XLEN-1:0]      ex_result_i,
  input  logic [bypass_pkg::XLEN-1:0]      wb_result_i,
  input  bypass_pkg::fw_sel_e              operand_a_sel_i,
  input  bypass_pkg::fw_sel_e              operand_b_sel_i,
  input  bypass_pkg::jfw_sel_e             jalr_sel_i,
  input  logic                             load_stall_i,
  input  logic                             jr_stall_i,
  input  logic                             wb_ready_i,
  output logic [1:0]                       rf_re_o,
  output logic [bypass_pkg::RF_ADDR_W-1:0] rf_raddr_a_o,
  output logic [bypass_pkg::RF_ADDR_W-1:0] rf_raddr_b_o,
  output logic                             jalr_id_o,
  output logic                             id_stall_o,
  output logic                             jump_o,
  output logic [bypass_pkg::XLEN-1:0]      jump_target_o,
  output logic                             id_ex_valid_o,
  output bypass_pkg::op_e                  id_ex_op_o,
  output logic [bypass_pkg::RF_ADDR_W-1:0] id_ex_rd_o,
  output logic [bypass_pkg::XLEN-1:0]      id_ex_opa_o,
  output logic [bypass_pkg::XLEN-1:0]      id_ex_opb_o
);

  logic                        use_rs2;
  logic                        use_imm;
  logic                        writes_rd;
  logic                        is_jalr;
  logic                        accept;
  logic [bypass_pkg::XLEN-1:0] fw_a;
  logic [bypass_pkg::XLEN-1:0] fw_b;
  logic [bypass_pkg::XLEN-1:0] jalr_base;

  // Three-way operand bypass
  function automatic logic [bypass_pkg::XLEN-1:0] fw_mux(
    input bypass_pkg::fw_sel_e        sel,
    input logic [bypass_pkg::XLEN-1:0] rf_val,
    input logic [bypass_pkg::XLEN-1:0] ex_val,
    input logic [bypass_pkg::XLEN-1:0] wb_val
  );
    case (sel)
      bypass_pkg::SEL_FW_EX: return ex_val;
      bypass_pkg::SEL_FW_WB: return wb_val;
      default:               return rf_val;
    endcase
  endfunction

  // Decode, every operation except NOP reads rs1
  assign use_rs2   = (op_i == bypass_pkg::OP_ADD) || (op_i == bypass_pkg::OP_SUB) ||
                     (op_i == bypass_pkg::OP_XOR);
  assign use_imm   = (op_i == bypass_pkg::OP_ADDI) || (op_i == bypass_pkg::OP_LOAD);
  assign writes_rd = use_rs2 || use_imm;
  assign is_jalr   = (op_i == bypass_pkg::OP_JALR);

  assign rf_re_o      = {instr_valid_i && use_rs2, instr_valid_i && (op_i != bypass_pkg::OP_NOP)};
  assign rf_raddr_a_o = rs1_i;
  assign rf_raddr_b_o = rs2_i;
  assign jalr_id_o    = instr_valid_i && is_jalr;

  assign fw_a = fw_mux(operand_a_sel_i, rf_rdata_a_i, ex_result_i, wb_result_i);
  assign fw_b = fw_mux(operand_b_sel_i, rf_rdata_b_i, ex_result_i, wb_result_i);

  // Jump target, resolved in ID
  assign jalr_base     = (jalr_sel_i == bypass_pkg::SELJ_FW_WB) ? wb_result_i : rf_rdata_a_i;
  assign jump_target_o = jalr_base + imm_i;

  // A waiting WB freezes the whole pipe
  assign id_stall_o = load_stall_i || jr_stall_i || !wb_ready_i;
  assign accept     = instr_valid_i && !id_stall_o;
  assign jump_o     = accept && is_jalr;

  //////////////////////////////////////////////////
  // ID/EX register
  //////////////////////////////////////////////////

  // Bubble when EX advances without a new writer, hold while WB waits
  always_ff @(posedge clk) begin
    if (reset_i) begin
      id_ex_valid_o <= 1'b0;
    end else if (wb_ready_i) begin
      id_ex_valid_o <= accept && writes_rd;
    end
  end

  always_ff @(posedge clk) begin
    if (wb_ready_i) begin
      id_ex_op_o  <= op_i;
      id_ex_rd_o  <= rd_i;
      id_ex_opa_o <= fw_a;
      id_ex_opb_o <= use_imm ? imm_i : fw_b;
    end
  end

  // An accepted instruction never reads the rd of a load still in EX
  load_use_held: assert property (@(posedge clk) disable iff (reset_i)
    (accept && id_ex_valid_o && (id_ex_op_o == bypass_pkg::OP_LOAD) && (id_ex_rd_o != '0))
    |-> !((rf_re_o[0] && (rf_raddr_a_o == id_ex_rd_o)) ||
          (rf_re_o[1] && (rf_raddr_b_o == id_ex_rd_o))));

endmodule

// ==== logic/mini_pipe_top.sv ====
`timescale 1ns/1ps
/*
 * Three-stage integer pipeline top level.
 * ID, EX and WB stages with the register file and the bypass controller.
 */
module mini_pipe_top (
  input  logic                             clk,
  input  logic                             reset_i,
  input  logic                             instr_valid_i,
  input  bypass_pkg::op_e                  op_i,
  input  logic [bypass_pkg::RF_ADDR_W-1:0] rd_i,
  input  logic [bypass_pkg::RF_ADDR_W-1:0] rs1_i,
  input  logic [bypass_pkg::RF_ADDR_W-1:0] rs2_i,
  input  logic [bypass_pkg::XLEN-1:0]      imm_i,
  input  logic                             mem_rvalid_i,
  input  logic [bypass_pkg::XLEN-1:0]      mem_rdata_i,
  output logic                             id_stall_o,
  output logic                             mem_req_o,
  output logic [bypass_pkg::XLEN-1:0]      mem_addr_o,
  output logic                             wb_valid_o,
  output logic [bypass_pkg::RF_ADDR_W-1:0] wb_rd_o,
  output logic [bypass_pkg::XLEN-1:0]      wb_data_o,
  output logic                             jump_o,
  output logic [bypass_pkg::XLEN-1:0]      jump_target_o
);

  // ID side
  logic [1:0]                       rf_re;
  logic [bypass_pkg::RF_ADDR_W-1:0] rf_raddr_a;
  logic [bypass_pkg::RF_ADDR_W-1:0] rf_raddr_b;
  logic [bypass_pkg::XLEN-1:0]      rf_rdata_a;
  logic [bypass_pkg::XLEN-1:0]      rf_rdata_b;
  logic                             jalr_id;
  bypass_pkg::fw_sel_e              operand_a_sel;
  bypass_pkg::fw_sel_e              operand_b_sel;
  bypass_pkg::jfw_sel_e             jalr_sel;
  logic                             load_stall;
  logic                             jr_stall;
  // ID/EX register
  logic                             id_ex_valid;
  bypass_pkg::op_e                  id_ex_op;
  logic [bypass_pkg::RF_ADDR_W-1:0] id_ex_rd;
  logic [bypass_pkg::XLEN-1:0]      id_ex_opa;
  logic [bypass_pkg::XLEN-1:0]      id_ex_opb;
  // EX state for the controller
  logic                             ex_valid;
  logic                             ex_we;
  logic                             ex_load;
  logic [bypass_pkg::RF_ADDR_W-1:0] ex_waddr;
  logic [bypass_pkg::XLEN-1:0]      ex_result;
  // EX/WB register
  logic                             ex_wb_valid;
  logic                             ex_wb_load;
  logic [bypass_pkg::RF_ADDR_W-1:0] ex_wb_rd;
  logic [bypass_pkg::XLEN-1:0]      ex_wb_result;
  // WB state and register file write
  logic                             wb_we;
  logic                             wb_load;
  logic                             wb_ready;
  logic                             rf_we;
  logic [bypass_pkg::XLEN-1:0]      rf_wdata;

  //////////////////////////////////////////////////
  // Stages
  //////////////////////////////////////////////////

  id_stage u_id (
    .clk, .reset_i, .instr_valid_i, .op_i, .rd_i, .rs1_i, .rs2_i, .imm_i,
    .rf_rdata_a_i    (rf_rdata_a),
    .rf_rdata_b_i    (rf_rdata_b),
    .ex_result_i     (ex_result),
    .wb_result_i     (wb_data_o),
    .operand_a_sel_i (operand_a_sel),
    .operand_b_sel_i (operand_b_sel),
    .jalr_sel_i      (jalr_sel),
    .load_stall_i    (load_stall),
    .jr_stall_i      (jr_stall),
    .wb_ready_i      (wb_ready),
    .rf_re_o         (rf_re),
    .rf_raddr_a_o    (rf_raddr_a),
    .rf_raddr_b_o    (rf_raddr_b),
    .jalr_id_o       (jalr_id),
    .id_stall_o, .jump_o, .jump_target_o,
    .id_ex_valid_o   (id_ex_valid),
    .id_ex_op_o      (id_ex_op),
    .id_ex_rd_o      (id_ex_rd),
    .id_ex_opa_o     (id_ex_opa),
    .id_ex_opb_o     (id_ex_opb)
  );

  ex_stage u_ex (
    .clk, .reset_i,
    .id_ex_valid_i  (id_ex_valid),
    .id_ex_op_i     (id_ex_op),
    .id_ex_rd_i     (id_ex_rd),
    .id_ex_opa_i    (id_ex_opa),
    .id_ex_opb_i    (id_ex_opb),
    .wb_ready_i     (wb_ready),
    .ex_valid_o     (ex_valid),
    .ex_we_o        (ex_we),
    .ex_load_o      (ex_load),
    .ex_waddr_o     (ex_waddr),
    .ex_result_o    (ex_result),
    .mem_req_o, .mem_addr_o,
    .ex_wb_valid_o  (ex_wb_valid),
    .ex_wb_load_o   (ex_wb_load),
    .ex_wb_rd_o     (ex_wb_rd),
    .ex_wb_result_o (ex_wb_result)
  );

  wb_stage u_wb (
    .clk, .reset_i,
    .ex_wb_valid_i  (ex_wb_valid),
    .ex_wb_load_i   (ex_wb_load),
    .ex_wb_rd_i     (ex_wb_rd),
    .ex_wb_result_i (ex_wb_result),
    .mem_rvalid_i, .mem_rdata_i, .wb_valid_o,
    .wb_we_o        (wb_we),
    .wb_load_o      (wb_load),
    .wb_waddr_o     (wb_rd_o),
    .wb_result_o    (wb_data_o),
    .wb_ready_o     (wb_ready),
    .rf_we_o        (rf_we),
    .rf_wdata_o     (rf_wdata)
  );

  //////////////////////////////////////////////////
  // Register file and controller
  //////////////////////////////////////////////////

  regfile u_rf (
    .clk, .reset_i,
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .we_i      (rf_we),
    .waddr_i   (wb_rd_o),
    .wdata_i   (rf_wdata),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b)
  );

  // WB valid is the occupancy of WB, a waiting load included
  hazard_bypass_ctrl u_ctrl (
    .rf_re_i         (rf_re),
    .rf_raddr_a_i    (rf_raddr_a),
    .rf_raddr_b_i    (rf_raddr_b),
    .jalr_id_i       (jalr_id),
    .ex_valid_i      (ex_valid),
    .ex_we_i         (ex_we),
    .ex_load_i       (ex_load),
    .ex_waddr_i      (ex_waddr),
    .wb_valid_i      (ex_wb_valid),
    .wb_we_i         (wb_we),
    .wb_load_i       (wb_load),
    .wb_waddr_i      (wb_rd_o),
    .wb_ready_i      (wb_ready),
    .operand_a_sel_o (operand_a_sel),
    .operand_b_sel_o (operand_b_sel),
    .jalr_sel_o      (jalr_sel),
    .load_stall_o    (load_stall),
    .jr_stall_o      (jr_stall)
  );

endmodule

// ==== logic/regfile.sv ====
`timescale 1ns/1ps
/*
 * Register file, 32 entries of 32 bits.
 * Two combinational read ports, one synchronous write port, r0 reads zero.
 */
module regfile (
  input  logic                             clk,
  input  logic                             reset_i,
  input  logic [bypass_pkg::RF_ADDR_W-1:0] raddr_a_i,
  input  logic [bypass_pkg::RF_ADDR_W-1:0] raddr_b_i,
  input  logic                             we_i,
  input  logic [bypass_pkg::RF_ADDR_W-1:0] waddr_i,
  input  logic [bypass_pkg::XLEN-1:0]      wdata_i,
  output logic [bypass_pkg::XLEN-1:0]      rdata_a_o,
  output logic [bypass_pkg::XLEN-1:0]      rdata_b_o
);

  logic [bypass_pkg::XLEN-1:0] regs_q [bypass_pkg::RF_NUM];

  // Write at the end of the WB cycle
  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < bypass_pkg::RF_NUM; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      // r0 is never written so it stays zero
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Reads see the old value, WB forwarding covers the same-cycle write
  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

endmodule

// ==== logic/wb_stage.sv ====
`timescale 1ns/1ps
/*
 * Write-back stage.
 * Holds a load until its data returns, then writes back and retires.
 */
module wb_stage (
  input  logic                             clk,
  input  logic                             reset_i,
  input  logic                             ex_wb_valid_i,
  input  logic                             ex_wb_load_i,
  input  logic [bypass_pkg::RF_ADDR_W-1:0] ex_wb_rd_i,
  input  logic [bypass_pkg::XLEN-1:0]      ex_wb_result_i,
  input  logic                             mem_rvalid_i,
  input  logic [bypass_pkg::XLEN-1:0]      mem_rdata_i,
  output logic                             wb_valid_o,
  output logic                             wb_we_o,
  output logic                             wb_load_o,
  output logic [bypass_pkg::RF_ADDR_W-1:0] wb_waddr_o,
  output logic [bypass_pkg::XLEN-1:0]      wb_result_o,
  output logic                             wb_ready_o,
  output logic                             rf_we_o,
  output logic [bypass_pkg::XLEN-1:0]      rf_wdata_o
);

  logic                        load_wait;
  logic                        park;
  logic                        pending_q;
  logic [bypass_pkg::XLEN-1:0] pending_data_q;

  // Load in WB, done once data is here
  assign load_wait  = ex_wb_valid_i && ex_wb_load_i;
  assign wb_ready_o = !load_wait || mem_rvalid_i || pending_q;
  assign wb_valid_o = ex_wb_valid_i && wb_ready_o;

  // Response with no waiting load to take it
  assign park = mem_rvalid_i && !(load_wait && !pending_q);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pending_q <= 1'b0;
    end else if (park) begin
      pending_q <= 1'b1;
    end else if (load_wait && pending_q) begin
      pending_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (park) begin
      pending_data_q <= mem_rdata_i;
    end
  end

  assign wb_we_o     = (ex_wb_rd_i != '0);
  assign wb_load_o   = ex_wb_load_i;
  assign wb_waddr_o  = ex_wb_rd_i;
  assign wb_result_o = !ex_wb_load_i ? ex_wb_result_i :
                       pending_q     ? pending_data_q : mem_rdata_i;
  assign rf_we_o     = wb_valid_o && wb_we_o;
  assign rf_wdata_o  = wb_result_o;

  // A parked response is taken before the next one arrives
  park_single: assert property (@(posedge clk) disable iff (reset_i)
    pending_q |-> !mem_rvalid_i);

endmodule

// ==== mini_pipe_top.f ====
logic/bypass_pkg.sv
logic/hazard_bypass_ctrl.sv
logic/regfile.sv
logic/id_stage.sv
logic/ex_stage.sv
logic/wb_stage.sv
logic/mini_pipe_top.sv
tests/tb_clock_gen.sv
tests/tb_mini_pipe.sv

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps
/*
 * Testbench clock and reset generator.
 * 40 ns clock, synchronous reset held for the first 4 rising edges.
 */
module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  localparam int HALF_PERIOD  = 20;
  localparam int RESET_CYCLES = 4;
  localparam int DRIVE_DELAY  = 2;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Release just after an edge, like every other DUT input
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #(DRIVE_DELAY);
    reset_o = 1'b0;
  end

endmodule

// ==== tests/tb_mini_pipe.sv ====
`timescale 1ns/1ps
/*
 * Testbench for the three-stage pipeline.
 * Random decoded instructions over r0..r7, a memory responder with random
 * wait states and an in-order register model that predicts every retire.
 */
module tb_mini_pipe;

  localparam int NUM_INSTR   = 400;
  localparam int CLK_PERIOD  = 40;
  localparam int DRIVE_DELAY = 2;
  localparam int WATCHDOG_NS = NUM_INSTR * 8 * CLK_PERIOD;
  localparam logic [bypass_pkg::XLEN-1:0] MEM_XOR = 32'hA5A5_0000;

  logic                             clk;
  logic                             reset;
  logic                             instr_valid;
  bypass_pkg::op_e                  op;
  logic [bypass_pkg::RF_ADDR_W-1:0] rd;
  logic [bypass_pkg::RF_ADDR_W-1:0] rs1;
  logic [bypass_pkg::RF_ADDR_W-1:0] rs2;
  logic [bypass_pkg::XLEN-1:0]      imm;
  logic                             mem_rvalid;
  logic [bypass_pkg::XLEN-1:0]      mem_rdata;
  logic                             id_stall;
  logic                             mem_req;
  logic [bypass_pkg::XLEN-1:0]      mem_addr;
  logic                             wb_valid;
  logic [bypass_pkg::RF_ADDR_W-1:0] wb_rd;
  logic [bypass_pkg::XLEN-1:0]      wb_data;
  logic                             jump;
  logic [bypass_pkg::XLEN-1:0]      jump_target;

  // Architectural model and expectation queues
  logic [bypass_pkg::XLEN-1:0]      arch_regs [bypass_pkg::RF_NUM];
  logic [bypass_pkg::RF_ADDR_W-1:0] exp_rd_q [$];
  logic [bypass_pkg::XLEN-1:0]      exp_data_q [$];
  logic [bypass_pkg::XLEN-1:0]      exp_addr_q [$];
  // Outstanding memory responses, due cycle and data
  int                               resp_due_q [$];
  logic [bypass_pkg::XLEN-1:0]      resp_data_q [$];

  integer                           seed;
  int                               err_count;
  int                               cycle_cnt;
  int                               last_due;
  int                               num_presented;
  int                               num_accepted;
  int                               num_jumps;
  int                               load_use_pairs;
  logic                             run_en;
  logic                             accepted;
  logic [bypass_pkg::RF_ADDR_W-1:0] prev_load_rd;

  tb_clock_gen u_clk (
    .clk_o   (clk),
    .reset_o (reset)
  );

  mini_pipe_top dut (
    .clk, .reset_i (reset),
    .instr_valid_i (instr_valid),
    .op_i          (op),
    .rd_i          (rd),
    .rs1_i         (rs1),
    .rs2_i         (rs2),
    .imm_i         (imm),
    .mem_rvalid_i  (mem_rvalid),
    .mem_rdata_i   (mem_rdata),
    .id_stall_o    (id_stall),
    .mem_req_o     (mem_req),
    .mem_addr_o    (mem_addr),
    .wb_valid_o    (wb_valid),
    .wb_rd_o       (wb_rd),
    .wb_data_o     (wb_data),
    .jump_o        (jump),
    .jump_target_o (jump_target)
  );

  // Small register range keeps hazards frequent
  function automatic logic [bypass_pkg::RF_ADDR_W-1:0] rand_reg();
    logic [2:0] r;
    r = $random(seed);
    return {2'b00, r};
  endfunction

  // Source usage per opcode, NOP reads nothing
  function automatic logic reads_reg(input bypass_pkg::op_e o,
                                     input logic [bypass_pkg::RF_ADDR_W-1:0] s1,
                                     input logic [bypass_pkg::RF_ADDR_W-1:0] s2,
                                     input logic [bypass_pkg::RF_ADDR_W-1:0] r);
    logic two_src;
    two_src = (o == bypass_pkg::OP_ADD) || (o == bypass_pkg::OP_SUB) ||
              (o == bypass_pkg::OP_XOR);
    return ((o != bypass_pkg::OP_NOP) && (s1 == r)) || (two_src && (s2 == r));
  endfunction

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  task automatic execute_model();
    logic [bypass_pkg::XLEN-1:0] a;
    logic [bypass_pkg::XLEN-1:0] b;
    logic [bypass_pkg::XLEN-1:0] res;
    logic                        writes;
    a      = arch_regs[rs1];
    b      = arch_regs[rs2];
    res    = '0;
    writes = 1'b1;
    case (op)
      bypass_pkg::OP_ADD:  res = a + b;
      bypass_pkg::OP_SUB:  res = a - b;
      bypass_pkg::OP_XOR:  res = a ^ b;
      bypass_pkg::OP_ADDI: res = a + imm;
      bypass_pkg::OP_LOAD: begin
        exp_addr_q.push_back(a + imm);
        res = (a + imm) ^ MEM_XOR;
      end
      bypass_pkg::OP_JALR: begin
        // Target resolved in ID, no register write
        writes = 1'b0;
        num_jumps++;
        assert (jump_target == a + imm) else begin
          err_count++;
          $display("ERROR @%0t: jump target %h, expected %h", $time, jump_target, a + imm);
        end
      end
      default: writes = 1'b0;
    endcase
    if (writes) begin
      exp_rd_q.push_back(rd);
      exp_data_q.push_back(res);
      // r0 stays zero in the model
      if (rd != '0) begin
        arch_regs[rd] = res;
      end
    end
    num_accepted++;
  endtask

  task automatic check_retire();
    logic [bypass_pkg::RF_ADDR_W-1:0] e_rd;
    logic [bypass_pkg::XLEN-1:0]      e_data;
    if (wb_valid) begin
      if (exp_rd_q.size() == 0) begin
        err_count++;
        $display("Retire at %0t with no instruction left to retire", $time);
      end else begin
        e_rd   = exp_rd_q.pop_front();
        e_data = exp_data_q.pop_front();
        assert ((wb_rd == e_rd) && (wb_data == e_data)) else begin
          err_count++;
          $display("ERROR @%0t: retire r%0d=%h, expected r%0d=%h",
                   $time, wb_rd, wb_data, e_rd, e_data);
        end
      end
    end
  endtask

  // Compare the address, then schedule the response in order
  task automatic check_mem_req();
    logic [bypass_pkg::XLEN-1:0] e_addr;
    int                          due;
    logic [1:0]                  wait_cycles;
    if (mem_req) begin
      if (exp_addr_q.size() == 0) begin
        err_count++;
        $display("Memory request at %0t with no load outstanding", $time);
      end else begin
        e_addr = exp_addr_q.pop_front();
        assert (mem_addr == e_addr) else begin
          err_count++;
          $display("ERROR @%0t: load address %h, expected %h", $time, mem_addr, e_addr);
        end
      end
      wait_cycles = $random(seed);
      due = cycle_cnt + 1 + wait_cycles;
      if (due <= last_due) begin
        due = last_due + 1;
      end
      last_due = due;
      resp_due_q.push_back(due);
      resp_data_q.push_back(mem_addr ^ MEM_XOR);
    end
  endtask

  // Dependent instruction right behind a load must stall
  task automatic check_load_use();
    if (instr_valid && (prev_load_rd != '0) && reads_reg(op, rs1, rs2, prev_load_rd)) begin
      load_use_pairs++;
      assert (id_stall) else begin
        err_count++;
        $display("ERROR @%0t: no stall for load-use on r%0d", $time, prev_load_rd);
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Monitor, sampled at the falling edge
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!reset) begin
      check_retire();
      check_mem_req();
      check_load_use();
      accepted = instr_valid && !id_stall;
      assert (jump == (accepted && (op == bypass_pkg::OP_JALR))) else begin
        err_count++;
        $display("ERROR @%0t: jump strobe %b, expected %b", $time, jump, !jump);
      end
      if (accepted) begin
        execute_model();
      end
      prev_load_rd = (accepted && (op == bypass_pkg::OP_LOAD)) ? rd : '0;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus and memory responder
  //////////////////////////////////////////////////

  task automatic drive_memory();
    mem_rvalid = 1'b0;
    if ((resp_due_q.size() > 0) && (resp_due_q[0] == cycle_cnt)) begin
      mem_rvalid = 1'b1;
      mem_rdata  = resp_data_q.pop_front();
      resp_due_q.delete(0);
    end
  endtask

  task automatic drive_instr();
    logic [2:0] op_bits;
    logic [2:0] gap;
    // Hold the instruction while ID stalls
    if (!instr_valid || accepted) begin
      gap = $random(seed);
      if ((num_presented == NUM_INSTR) || (gap == 3'd0)) begin
        instr_valid = 1'b0;
      end else begin
        op_bits     = $random(seed);
        op          = (op_bits == 3'd7) ? bypass_pkg::OP_LOAD : bypass_pkg::op_e'(op_bits);
        rd          = rand_reg();
        rs1         = rand_reg();
        rs2         = rand_reg();
        imm         = $random(seed);
        instr_valid = 1'b1;
        num_presented++;
      end
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    #(DRIVE_DELAY);
    drive_memory();
    if (run_en) begin
      drive_instr();
    end
  end

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    seed           = 14017;
    err_count      = 0;
    cycle_cnt      = 0;
    last_due       = 0;
    num_presented  = 0;
    num_accepted   = 0;
    num_jumps      = 0;
    load_use_pairs = 0;
    run_en         = 1'b0;
    accepted       = 1'b0;
    prev_load_rd   = '0;
    instr_valid    = 1'b0;
    op             = bypass_pkg::OP_NOP;
    rd             = '0;
    rs1            = '0;
    rs2            = '0;
    imm            = '0;
    mem_rvalid     = 1'b0;
    mem_rdata      = '0;
    for (int i = 0; i < bypass_pkg::RF_NUM; i++) begin
      arch_regs[i] = '0;
    end

    @(negedge reset);
    @(negedge clk);
    assert (!id_stall && !mem_req && !wb_valid && !jump) else begin
      err_count++;
      $display("ERROR @%0t: outputs active after reset", $time);
    end
    run_en = 1'b1;

    // Run until everything issued has drained
    while (num_accepted < NUM_INSTR) @(negedge clk);
    while ((exp_rd_q.size() != 0) || (exp_addr_q.size() != 0) || (resp_due_q.size() != 0))
      @(negedge clk);
    repeat (4) @(negedge clk);

    $display("Done: %0d instructions, %0d jumps, %0d load-use pairs, %0d errors",
             num_accepted, num_jumps, load_use_pairs, err_count);
    if (err_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired at %0t, the pipeline hung with %0d of %0d accepted, %0d errors",
             $time, num_accepted, NUM_INSTR, err_count);
    $display("Checks failed");
    $finish;
  end

endmodule
